/* filelist.f */
audio_pkg.sv
apb_regs_pkg.sv
sample_tick.sv
adc_capture.sv
iir_filter_bank.sv
dac_shift_out.sv
apb_ctrl_regs.sv
audio_filter_top.sv
tb_adc_dac_model.sv
tb_audio_filter.sv

/* Makefile */
TOOL     := verilator
TOP      := tb_audio_filter
FILELIST := filelist.f
FLAGS    := --binary --timing --assert -Wno-fatal
LINT     := --lint-only --timing -Wall
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_audio_filter.sv */
// Testbench for the audio filter path
// Sets up routing over APB, feeds the ADC model and checks every DAC
// frame against a reference of the shift IIR rule
module tb_audio_filter
  import audio_pkg::*;
  import apb_regs_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DIV_RESET = 40;
  localparam int DIV_MIN   = 20;
  localparam int DIV_RUN   = 64;    // Slack to stop before the next tick
  localparam int APB_TO    = 16;    // Cycles

  logic        clk;
  logic        rst_n;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        adc_miso;
  logic        adc_cs_n;
  logic        adc_mosi;
  logic        dac_cs_n;
  logic        dac_mosi;
  logic [11:0] stim_q[$];           // Samples for the next run
  logic        bad_q[$];            // Null bit error per sample
  logic [11:0] exp_q[$];            // Expected DAC data
  int          err_cnt;
  int          sat_pred;            // Clips the reference predicts
  int          test_cnt;
  int          fail_tests;

  audio_filter_top #(.DIV_RESET(DIV_RESET), .DIV_MIN(DIV_MIN)) dut0 (
    .clk(clk), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .adc_miso(adc_miso), .adc_cs_n(adc_cs_n), .adc_mosi(adc_mosi),
    .dac_cs_n(dac_cs_n), .dac_mosi(dac_mosi));

  tb_adc_dac_model model0 (
    .clk(clk), .adc_cs_n(adc_cs_n), .adc_mosi(adc_mosi), .adc_miso(adc_miso),
    .dac_cs_n(dac_cs_n), .dac_mosi(dac_mosi));

  initial clk = 1'b0;
  always #2 clk = ~clk;             // 4 ns period

  // ==============================
  // Checking helpers
  // ==============================
  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR @%0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    $display("Timeout: %s", why);
    $display("*** FAILED ***");
    $finish;
  endtask

  // Expected route value, returns {clipped, data}
  function automatic logic [12:0] ref_filter(input shortint fast, input shortint slow,
      input int sh, input filter_sel_e sel, input int x,
      output shortint fast_n, output shortint slow_n);
    int   s_f;
    int   s_s;
    int   pick;
    int   y;
    logic sat;
    s_f    = (sh == 0) ? 1 : sh;
    s_s    = (s_f + 2 > 7) ? 7 : s_f + 2;
    fast_n = shortint'(fast + ((x - fast) >>> s_f));
    slow_n = shortint'(slow + ((x - slow) >>> s_s));
    case (sel)
      SEL_LOW:  pick = fast_n;
      SEL_BAND: pick = fast_n - slow_n;
      SEL_HIGH: pick = x - fast_n;
      default:  pick = x;
    endcase
    sat = (pick > 2047) || (pick < -2048);
    y   = (pick > 2047) ? 2047 : ((pick < -2048) ? -2048 : pick);
    return {sat, y[11:0]};
  endfunction

  function automatic logic [31:0] ctrl_word(input logic en, input filter_sel_e sel,
      input int sh, input int ch);
    return {21'd0, 3'(ch), 1'b0, 3'(sh), 1'b0, 2'(sel), en};
  endfunction

  // Compare process, one DAC frame per pop
  always @(posedge clk) begin
    logic [15:0] w;
    if (model0.dac_pending() > 0) begin
      model0.pop_frame(w);
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("DAC frame 0x%0h arrived at %0t ns with no sample pending", w, $time);
      end else begin
        check("DAC command", 32'(w[15:12]), 32'(DAC_CMD));
        check("DAC data", 32'(w[11:0]), 32'(exp_q.pop_front()));
      end
    end
  end

  // ==============================
  // APB and stream tasks
  // ==============================
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
      output logic [31:0] rdata, output logic slverr);
    int n;
    n = 0;
    @(negedge clk);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(negedge clk);
    apb_req.penable = 1'b1;           // Access phase
    #1;
    while (!apb_rsp.pready && (n < APB_TO)) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!apb_rsp.pready)
      abort_run("APB transfer never completed");
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
    logic [31:0] rd;
    logic        se;
    apb_xfer(1'b1, addr, wdata, rd, se);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] rd, output logic se);
    apb_xfer(1'b0, addr, 32'd0, rd, se);
  endtask

  task automatic load_random(input int n);
    for (int k = 0; k < n; k++) begin
      stim_q.push_back(12'($urandom));
      bad_q.push_back(1'b0);
    end
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while ((exp_q.size() > 0) && (n < limit)) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() > 0)
      abort_run("DAC frames stopped before every sample came back");
  endtask

  // Predict, queue, enable, drain, disable
  task automatic run_stream(input filter_sel_e sel, input int sh, input int ch);
    shortint     fast;
    shortint     slow;
    shortint     fast_n;
    shortint     slow_n;
    logic [12:0] r;
    int          n;
    fast = 0;                         // Filter states start cleared
    slow = 0;
    n    = stim_q.size();
    apb_write(ADDR_CTRL, ctrl_word(1'b0, sel, sh, ch));
    while (stim_q.size() > 0) begin
      r    = ref_filter(fast, slow, sh, sel, int'($signed(stim_q[0])), fast_n, slow_n);
      fast = fast_n;
      slow = slow_n;
      sat_pred += int'(r[12]);
      exp_q.push_back(r[11:0]);
      model0.push_sample(stim_q.pop_front(), bad_q.pop_front());
    end
    apb_write(ADDR_CTRL, ctrl_word(1'b1, sel, sh, ch));
    wait_drained((n + 2) * DIV_RUN);
    apb_write(ADDR_CTRL, ctrl_word(1'b0, sel, sh, ch));
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      fail_tests++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
    end
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    logic [31:0]        rd;
    logic               se;
    int                 e0;
    logic signed [11:0] last;
    int                 shifts [3];
    filter_sel_e        sels [3];
    shifts = '{1, 3, 7};
    sels   = '{SEL_LOW, SEL_BAND, SEL_HIGH};
    void'($urandom(32'hfed9dc74));
    apb_req    = '0;
    rst_n      = 1'b0;
    err_cnt    = 0;
    sat_pred   = 0;
    test_cnt   = 0;
    fail_tests = 0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // Reset values, clamp, unmapped address
    e0 = err_cnt;
    apb_read(ADDR_CTRL, rd, se);
    check("CTRL after reset", rd, 32'd0);
    apb_read(ADDR_DIV, rd, se);
    check("DIV after reset", rd, 32'(DIV_RESET));
    check("ADC cs_n idle", 32'(adc_cs_n), 32'd1);
    check("DAC cs_n idle", 32'(dac_cs_n), 32'd1);
    apb_write(ADDR_DIV, 32'd5);
    apb_read(ADDR_DIV, rd, se);
    check("DIV clamped", rd, 32'(DIV_MIN));
    apb_read(8'h20, rd, se);
    check("pslverr on 0x20", 32'(se), 32'd1);
    end_test("reset and registers", e0);
    apb_write(ADDR_DIV, 32'(DIV_RUN));

    // Raw route on channel 5
    e0 = err_cnt;
    load_random(20);
    last = stim_q[19];
    run_stream(SEL_RAW, 1, 5);
    check("ADC command", 32'(model0.adc_cmd), 32'b1101);
    apb_read(ADDR_COUNT, rd, se);
    check("COUNT", rd, 32'd20);
    apb_read(ADDR_LAST, rd, se);
    check("LAST", rd, {{20{last[11]}}, last});
    end_test("raw route", e0);

    e0 = err_cnt;
    foreach (sels[i]) begin
      foreach (shifts[j]) begin
        load_random(12);
        run_stream(sels[i], shifts[j], 3);
      end
    end
    end_test("filter routes", e0);

    // Full scale steps on the high route
    e0 = err_cnt;
    apb_write(ADDR_STATUS, 32'd0);
    sat_pred = 0;
    for (int b = 0; b < 4; b++) begin
      for (int k = 0; k < 8; k++) begin
        stim_q.push_back((b % 2 == 1) ? 12'h7FF : 12'h800);
        bad_q.push_back(1'b0);
      end
    end
    run_stream(SEL_HIGH, 3, 0);
    apb_read(ADDR_STATUS, rd, se);
    check("saturation count", 32'(rd[15:0]), 32'(sat_pred));
    end_test("saturation", e0);

    e0 = err_cnt;
    apb_write(ADDR_STATUS, 32'd0);
    load_random(8);
    bad_q[1] = 1'b1;
    bad_q[4] = 1'b1;
    bad_q[6] = 1'b1;
    run_stream(SEL_RAW, 1, 2);
    apb_read(ADDR_STATUS, rd, se);
    check("frame error count", 32'(rd[31:16]), 32'd3);
    check("saturation count raw", 32'(rd[15:0]), 32'd0);
    apb_write(ADDR_STATUS, 32'd0);
    apb_read(ADDR_STATUS, rd, se);
    check("STATUS cleared", rd, 32'd0);
    end_test("frame errors", e0);

    $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* tb_adc_dac_model.sv */
// Converter models for the audio path testbench
// ADC side serves queued samples and records the channel command,
// DAC side decodes each 16 bit frame into a queue
module tb_adc_dac_model (
  input  logic clk,
  input  logic adc_cs_n,
  input  logic adc_mosi,
  output logic adc_miso,
  input  logic dac_cs_n,
  input  logic dac_mosi
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [15:0] adc_q[$];    // Null nibble and data per conversion
  logic [15:0] dac_q[$];    // Decoded DAC frames
  logic [15:0] adc_word;
  logic [3:0]  cmd_sr;
  logic [3:0]  adc_cmd;     // Last start bit and channel seen
  logic [15:0] dac_sr;
  int          adc_idx;
  int          dac_idx;

  initial begin
    adc_miso = 1'b0;
    adc_word = '0;
    cmd_sr   = '0;
    adc_cmd  = '0;
    dac_sr   = '0;
    adc_idx  = 0;
    dac_idx  = 0;
  end

  task automatic push_sample(input logic [11:0] data, input logic bad_null);
    adc_q.push_back({(bad_null ? 4'b1010 : 4'b0000), data});   // Bad frame has ones in nulls
  endtask

  function automatic int dac_pending();
    return dac_q.size();
  endfunction

  task automatic pop_frame(output logic [15:0] word);
    word = dac_q.pop_front();
  endtask

  // ==============================
  // ADC, bits change on the falling edge
  // ==============================
  always @(negedge clk) begin
    if (adc_cs_n) begin
      adc_idx  = 0;
      adc_miso = 1'b0;
    end else if (adc_idx < 16) begin
      if (adc_idx == 0) begin
        if (adc_q.size() > 0)
          adc_word = adc_q.pop_front();   // New conversion
        else
          adc_word = '0;
      end
      adc_miso = adc_word[15 - adc_idx];
      if (adc_idx < 4)
        cmd_sr = {cmd_sr[2:0], adc_mosi};
      if (adc_idx == 3)
        adc_cmd = cmd_sr;
      adc_idx++;
    end
  end

  // DAC receiver, mid cycle sampling
  always @(negedge clk) begin
    if (dac_cs_n) begin
      dac_idx = 0;
    end else begin
      dac_sr = {dac_sr[14:0], dac_mosi};
      dac_idx++;
      if (dac_idx == 16)
        dac_q.push_back(dac_sr);
    end
  end

endmodule

/* audio_filter_top.sv */
// Audio filter path top level
// Divider, ADC capture, IIR bank and DAC serializer under APB control
module audio_filter_top
  import audio_pkg::*;
  import apb_regs_pkg::*;
#(
  parameter int DIV_RESET = 40,   // Divider after reset
  parameter int DIV_MIN   = 20    // Frame length plus margin
) (
  input  logic     clk,           // Also the converter serial clock
  input  logic     rst_n,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp,
  input  logic     adc_miso,
  output logic     adc_cs_n,
  output logic     adc_mosi,
  output logic     dac_cs_n,
  output logic     dac_mosi
);

  // ==============================
  // Stage wiring
  // ==============================
  ctrl_t        ctrl;       // Register fields to all stages
  logic         tick;       // Conversion start
  sample_beat_t adc_beat;   // Captured sample
  sample_beat_t dac_beat;   // Routed, saturated sample

  apb_ctrl_regs #(
    .DIV_RESET (DIV_RESET),
    .DIV_MIN   (DIV_MIN)
  ) regs0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .dac_beat (dac_beat),
    .ctrl     (ctrl)
  );

  sample_tick #(.DIV_MIN(DIV_MIN)) tick0 (.clk(clk), .rst_n(rst_n), .ctrl(ctrl), .tick(tick));

  adc_capture adc0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .tick     (tick),
    .adc_miso (adc_miso),
    .adc_cs_n (adc_cs_n),
    .adc_mosi (adc_mosi),
    .adc_beat (adc_beat)
  );

  iir_filter_bank filt0 (.clk(clk), .rst_n(rst_n), .ctrl(ctrl),
                         .adc_beat(adc_beat), .dac_beat(dac_beat));

  dac_shift_out dac0 (.clk(clk), .rst_n(rst_n), .dac_beat(dac_beat),
                      .dac_cs_n(dac_cs_n), .dac_mosi(dac_mosi));

endmodule

/* apb_ctrl_regs.sv */
// APB control and status registers
// Routing, shift, channel and divider setup, plus sample,
// saturation and frame error counters fed from the DAC stream
module apb_ctrl_regs
  import audio_pkg::*;
  import apb_regs_pkg::*;
#(
  parameter int DIV_RESET = 40,
  parameter int DIV_MIN   = 20
) (
  input  logic         clk,
  input  logic         rst_n,
  input  apb_req_t     apb_req,
  output apb_rsp_t     apb_rsp,
  input  sample_beat_t dac_beat,
  output ctrl_t        ctrl
);

  ctrl_t                   ctrl_q;
  logic [15:0]             sat_cnt;
  logic [15:0]             ferr_cnt;
  logic [31:0]             smp_cnt;
  logic signed [SMP_W-1:0] last_smp;
  logic [31:0]             rdata;
  logic [15:0]             div_wr;
  logic                    access;
  logic                    wr_en;
  logic                    mapped;

  assign access = apb_req.psel && apb_req.penable;   // Access phase
  assign wr_en  = access && apb_req.pwrite;
  assign div_wr = (apb_req.pwdata[15:0] < 16'(DIV_MIN)) ? 16'(DIV_MIN)
                                                        : apb_req.pwdata[15:0];

  // ==============================
  // Control registers
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q <= '{enable: 1'b0, sel: SEL_RAW, shift: 3'd0, channel: 3'd0,
                  div: 16'(DIV_RESET)};
    end else if (wr_en) begin
      if (apb_req.paddr == ADDR_CTRL) begin
        ctrl_q.enable  <= apb_req.pwdata[0];
        ctrl_q.sel     <= filter_sel_e'(apb_req.pwdata[2:1]);
        ctrl_q.shift   <= apb_req.pwdata[6:4];
        ctrl_q.channel <= apb_req.pwdata[10:8];
      end
      if (apb_req.paddr == ADDR_DIV)
        ctrl_q.div <= div_wr;                          // Clamped to one frame plus margin
    end
  end

  assign ctrl = ctrl_q;

  // Status counters, STATUS write wins over a beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sat_cnt  <= '0;
      ferr_cnt <= '0;
      smp_cnt  <= '0;
      last_smp <= '0;
    end else begin
      if (wr_en && (apb_req.paddr == ADDR_STATUS)) begin
        sat_cnt  <= '0;
        ferr_cnt <= '0;
      end else if (dac_beat.valid) begin
        sat_cnt  <= sat_cnt + 16'(dac_beat.smp.err[ERR_SAT]);
        ferr_cnt <= ferr_cnt + 16'(dac_beat.smp.err[ERR_FRAME]);
      end
      if (dac_beat.valid) begin
        smp_cnt  <= smp_cnt + 32'd1;
        last_smp <= dac_beat.smp.data;
      end
    end
  end

  // ==============================
  // Read mux
  // ==============================
  always_comb begin
    mapped = 1'b1;
    rdata  = '0;
    case (apb_req.paddr)
      ADDR_CTRL:   rdata = {21'd0, ctrl_q.channel, 1'b0, ctrl_q.shift, 1'b0,
                            ctrl_q.sel, ctrl_q.enable};
      ADDR_DIV:    rdata = {16'd0, ctrl_q.div};
      ADDR_STATUS: rdata = {ferr_cnt, sat_cnt};
      ADDR_COUNT:  rdata = smp_cnt;
      ADDR_LAST:   rdata = {{(32 - SMP_W){last_smp[SMP_W-1]}}, last_smp};
      default:     mapped = 1'b0;
    endcase
  end

  assign apb_rsp.prdata  = rdata;
  assign apb_rsp.pready  = 1'b1;                       // No wait states
  assign apb_rsp.pslverr = access && !mapped;

  // Bus protocol checks on the master side
  a_penable_in_sel: assert property (@(posedge clk) disable iff (!rst_n)
    apb_req.penable |-> apb_req.psel);
  a_setup_to_access: assert property (@(posedge clk) disable iff (!rst_n)
    (apb_req.psel && !apb_req.penable) |=> (apb_req.penable && $stable(apb_req.paddr)
      && $stable(apb_req.pwrite) && (!apb_req.pwrite || $stable(apb_req.pwdata))));

endmodule

/* dac_shift_out.sv */
// Serial DAC frame engine
// Shifts the write-and-update command and the 12 bit sample, MSB first
module dac_shift_out
  import audio_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  sample_beat_t dac_beat,
  output logic         dac_cs_n,
  output logic         dac_mosi
);

  ser_state_e            state;
  logic [CNT_W-1:0]      bit_cnt;
  logic [FRAME_BITS-1:0] sr;       // Command nibble then data
  logic                  load;

  assign load = dac_beat.valid && (state != S_SHIFT);

  // ==============================
  // Frame control
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= S_IDLE;
      bit_cnt <= '0;
    end else begin
      case (state)
        S_SHIFT: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == CNT_W'(FRAME_BITS - 1))
            state <= S_DONE;         // CS rises after 16 bits
        end
        default: begin
          if (load) begin
            state   <= S_SHIFT;
            bit_cnt <= '0;
          end else begin
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load)
      sr <= {DAC_CMD, dac_beat.smp.data};
    else if (state == S_SHIFT)
      sr <= {sr[FRAME_BITS-2:0], 1'b0};
  end

  assign dac_cs_n = (state != S_SHIFT);                  // Low 1 clock after the beat
  assign dac_mosi = (state == S_SHIFT) && sr[FRAME_BITS-1];

  // Sample period covers a full frame, beats never land mid frame
  a_no_beat_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
    (state == S_SHIFT) |-> !dac_beat.valid);

endmodule

/* iir_filter_bank.sv */
// Shift coefficient IIR filter bank
// Two first order lowpass states give low, band and high outputs,
// the selected route is saturated to 12 bits
module iir_filter_bank
  import audio_pkg::*;
  import apb_regs_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  ctrl_t        ctrl,
  input  sample_beat_t adc_beat,
  output sample_beat_t dac_beat
);

  localparam int ST_W = 16;   // Filter state width
  localparam logic signed [ST_W:0] Y_MAX = (2 ** (SMP_W - 1)) - 1;
  localparam logic signed [ST_W:0] Y_MIN = -(2 ** (SMP_W - 1));

  logic signed [ST_W-1:0]  lp_fast;     // Shift s
  logic signed [ST_W-1:0]  lp_slow;     // Shift s+2, capped at 7
  logic signed [ST_W-1:0]  fast_n;
  logic signed [ST_W-1:0]  slow_n;
  logic signed [SMP_W-1:0] x;
  logic signed [ST_W:0]    x_ext;
  logic signed [ST_W:0]    fast_sum;
  logic signed [ST_W:0]    slow_sum;
  logic signed [ST_W:0]    pick;        // Route before saturation
  logic signed [SMP_W-1:0] y;
  logic [2:0]              sh_fast;
  logic [2:0]              sh_slow;
  logic                    sat;
  logic [1:0]              err_v;
  logic                    out_valid;
  sample_t                 out_smp;

  assign x       = adc_beat.smp.data;
  assign sh_fast = (ctrl.shift == 3'd0) ? 3'd1 : ctrl.shift;
  assign sh_slow = (sh_fast > 3'd5) ? 3'd7 : sh_fast + 3'd2;

  // ==============================
  // State update and routing
  // ==============================
  always_comb begin
    x_ext    = x;                                           // Sign extend
    fast_sum = lp_fast + ((x_ext - lp_fast) >>> sh_fast);   // state += (x - state) >> s
    slow_sum = lp_slow + ((x_ext - lp_slow) >>> sh_slow);
    fast_n   = fast_sum[ST_W-1:0];
    slow_n   = slow_sum[ST_W-1:0];

    // Outputs use the freshly updated states
    case (ctrl.sel)
      SEL_LOW:  pick = fast_n;
      SEL_BAND: pick = fast_n - slow_n;
      SEL_HIGH: pick = x_ext - fast_n;
      default:  pick = x_ext;                               // Raw
    endcase

    // Clip to 12 bit signed
    sat = 1'b1;
    if (pick > Y_MAX)
      y = Y_MAX[SMP_W-1:0];
    else if (pick < Y_MIN)
      y = Y_MIN[SMP_W-1:0];
    else begin
      y   = pick[SMP_W-1:0];
      sat = 1'b0;
    end

    err_v            = '0;
    err_v[ERR_SAT]   = sat;
    err_v[ERR_FRAME] = adc_beat.smp.err[ERR_FRAME];         // Passed through
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lp_fast   <= '0;
      lp_slow   <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= adc_beat.valid;                          // One clock latency
      if (!ctrl.enable) begin
        lp_fast <= '0;                                      // Fresh start on next enable
        lp_slow <= '0;
      end else if (adc_beat.valid) begin
        lp_fast <= fast_n;
        lp_slow <= slow_n;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (adc_beat.valid) begin
      out_smp.data <= y;
      out_smp.err  <= err_v;
    end
  end

  assign dac_beat.valid = out_valid;
  assign dac_beat.smp   = out_smp;

endmodule

/* adc_capture.sv */
// Serial ADC frame engine
// Sends start bit and channel, captures 4 null bits and 12 data bits,
// flags a frame error when a null bit reads back as 1
module adc_capture
  import audio_pkg::*;
  import apb_regs_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  ctrl_t        ctrl,
  input  logic         tick,
  input  logic         adc_miso,
  output logic         adc_cs_n,
  output logic         adc_mosi,
  output sample_beat_t adc_beat
);

  localparam int NULL_BITS = FRAME_BITS - SMP_W;   // Leading zeros from the ADC

  ser_state_e       state;
  logic [CNT_W-1:0] bit_cnt;     // Bit being transferred
  logic [3:0]       cmd_sr;      // Start bit then channel, MSB first
  logic [SMP_W-1:0] data_sr;     // Last 12 bits in hold the sample
  logic             null_err;
  logic             start;
  logic [1:0]       err_v;

  assign start = tick && (state != S_SHIFT);

  // ==============================
  // Frame control
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      bit_cnt  <= '0;
      null_err <= 1'b0;
    end else begin
      case (state)
        S_SHIFT: begin
          bit_cnt <= bit_cnt + 1'b1;
          if ((bit_cnt < CNT_W'(NULL_BITS)) && adc_miso)
            null_err <= 1'b1;              // Null bit not zero
          if (bit_cnt == CNT_W'(FRAME_BITS - 1))
            state <= S_DONE;
        end
        default: begin                     // Idle or done, beat goes out in done
          if (start) begin
            state    <= S_SHIFT;
            bit_cnt  <= '0;
            null_err <= 1'b0;
          end else begin
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

  // Shift registers, payload only
  always_ff @(posedge clk) begin
    if (start)
      cmd_sr <= {1'b1, ctrl.channel};      // Channel latched at conversion start
    else if (state == S_SHIFT)
      cmd_sr <= {cmd_sr[2:0], 1'b0};
    if (state == S_SHIFT)
      data_sr <= {data_sr[SMP_W-2:0], adc_miso};   // Sampled on rising edge
  end

  // ==============================
  // Outputs
  // ==============================
  assign adc_cs_n = (state != S_SHIFT);
  assign adc_mosi = (state == S_SHIFT) && cmd_sr[3];  // Zero after the command nibble

  always_comb begin
    err_v            = '0;
    err_v[ERR_FRAME] = null_err;
  end

  assign adc_beat.valid    = (state == S_DONE);      // 17 clocks after tick
  assign adc_beat.smp.data = data_sr;
  assign adc_beat.smp.err  = err_v;

  // DIV_MIN in the divider keeps ticks outside a frame
  a_no_tick_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
    (state == S_SHIFT) |-> !tick);

endmodule

/* sample_tick.sv */
// Sample rate divider
// One conversion start every div clocks while enabled
module sample_tick
  import apb_regs_pkg::*;
#(
  parameter int DIV_MIN = 20
) (
  input  logic  clk,
  input  logic  rst_n,
  input  ctrl_t ctrl,
  output logic  tick
);

  logic [15:0] cnt;      // Clocks left until next tick
  logic [15:0] period;

  // Guard against a period shorter than one frame
  assign period = (ctrl.div < 16'(DIV_MIN)) ? 16'(DIV_MIN) : ctrl.div;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!ctrl.enable) begin
      cnt <= '0;                    // Held clear, restarts on enable
    end else if (cnt <= 16'd1) begin
      cnt <= period;                // First enabled cycle or tick cycle
    end else begin
      cnt <= cnt - 16'd1;
    end
  end

  assign tick = ctrl.enable && (cnt == 16'd1);

  // Period is never below DIV_MIN so ticks are always spaced
  a_tick_spacing: assert property (@(posedge clk) disable iff (!rst_n)
    tick |=> !tick);

endmodule

/* apb_regs_pkg.sv */
// APB register map of the audio path
// Bus request/response structs, addresses and the control fields
package apb_regs_pkg;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;    // Tied high, zero wait states
    logic        pslverr;   // Unmapped address
  } apb_rsp_t;

  // ==============================
  // Register addresses
  // ==============================
  localparam logic [7:0] ADDR_CTRL   = 8'h00;   // En [0], sel [2:1], shift [6:4], chan [10:8]
  localparam logic [7:0] ADDR_DIV    = 8'h04;   // Sample period in clocks
  localparam logic [7:0] ADDR_STATUS = 8'h08;   // Sat count [15:0], frame errs [31:16]
  localparam logic [7:0] ADDR_COUNT  = 8'h0C;   // Samples sent to DAC
  localparam logic [7:0] ADDR_LAST   = 8'h10;   // Last DAC value, sign extended

  // Control fields fanned out to every stage
  typedef struct packed {
    logic                    enable;
    audio_pkg::filter_sel_e  sel;
    logic [2:0]              shift;     // 0 acts as 1
    logic [2:0]              channel;   // ADC input mux
    logic [15:0]             div;
  } ctrl_t;

endpackage

/* audio_pkg.sv */
// Audio path stream types
// Sample beats between stages, route select, serial engine states
// and the converter frame constants
package audio_pkg;

  // ==============================
  // Frame constants
  // ==============================
  localparam int SMP_W      = 12;                   // Converter sample width
  localparam int FRAME_BITS = 16;                   // One CS low window
  localparam int CNT_W      = $clog2(FRAME_BITS);   // Bit counter width
  localparam logic [3:0] DAC_CMD = 4'b0011;         // Write and update DAC register

  // Error flag positions inside sample_t.err
  localparam int ERR_SAT   = 0;
  localparam int ERR_FRAME = 1;

  // ==============================
  // Stream types
  // ==============================
  typedef struct packed {
    logic signed [SMP_W-1:0] data;   // Two's complement sample
    logic        [1:0]       err;    // Saturation, ADC frame error
  } sample_t;

  // One cycle beat, no ready
  typedef struct packed {
    logic    valid;
    sample_t smp;
  } sample_beat_t;

  // Same order as the board switcher inputs
  typedef enum logic [1:0] {
    SEL_RAW  = 2'd0,
    SEL_LOW  = 2'd1,
    SEL_BAND = 2'd2,
    SEL_HIGH = 2'd3
  } filter_sel_e;

  // Shared by ADC and DAC frame engines
  typedef enum logic [1:0] {
    S_IDLE,
    S_SHIFT,
    S_DONE
  } ser_state_e;

endpackage
